//--- design/cce_params.svh
`ifndef CCE_PARAMS_SVH
`define CCE_PARAMS_SVH

// Raw microinstruction width
`define CCE_INST_W 32

// Immediate field carried in every instruction
`define CCE_IMM_W 16

// General purpose register file
`define CCE_NUM_GPR 8
`define CCE_GPR_IDX_W 3

// Microcode program counter, branch targets use the low immediate bits
`define CCE_PC_W 8

// Sources watched by wfq: lce_req, lce_resp, mem_resp, pending
`define CCE_NUM_SRC_Q 4

`endif

//--- design/cce_pkg.sv
`include "cce_params.svh"

package cce_pkg;

  // Vectors with their own meaning
  typedef logic [`CCE_INST_W-1:0]    cce_inst_t;
  typedef logic [`CCE_IMM_W-1:0]     cce_imm_t;
  typedef logic [`CCE_GPR_IDX_W-1:0] cce_gpr_idx_t;
  typedef logic [`CCE_NUM_GPR-1:0]   cce_gpr_mask_t;
  typedef logic [`CCE_PC_W-1:0]      cce_pc_t;

  // High to low: lce_req, lce_resp, mem_resp, pending
  typedef logic [`CCE_NUM_SRC_Q-1:0] cce_q_mask_t;

  typedef enum logic [2:0] {
    e_op_alu    = 3'd0,
    e_op_branch = 3'd1,
    e_op_move   = 3'd2,
    e_op_misc   = 3'd3,
    e_op_queue  = 3'd4
  } cce_op_e;

  // Minor op codes are reused by every opcode
  // The ALU names own the enum, the other classes alias the same values
  typedef enum logic [2:0] {
    e_add_op = 3'd0,
    e_sub_op = 3'd1,
    e_and_op = 3'd2,
    e_or_op  = 3'd3
  } cce_minor_e;

  localparam cce_minor_e e_beq_op   = cce_minor_e'(3'd0);
  localparam cce_minor_e e_bne_op   = cce_minor_e'(3'd1);
  localparam cce_minor_e e_bi_op    = cce_minor_e'(3'd2);
  localparam cce_minor_e e_mov_op   = cce_minor_e'(3'd0);
  localparam cce_minor_e e_movi_op  = cce_minor_e'(3'd1);
  localparam cce_minor_e e_stall_op = cce_minor_e'(3'd0);
  localparam cce_minor_e e_pushq_op = cce_minor_e'(3'd0);
  localparam cce_minor_e e_popq_op  = cce_minor_e'(3'd1);
  localparam cce_minor_e e_poph_op  = cce_minor_e'(3'd2);
  localparam cce_minor_e e_wfq_op   = cce_minor_e'(3'd3);

  typedef enum logic [2:0] {
    e_dst_q_lce_cmd = 3'd0,
    e_dst_q_mem_cmd = 3'd1
  } cce_dst_q_e;

  typedef enum logic [2:0] {
    e_src_q_lce_req  = 3'd0,
    e_src_q_lce_resp = 3'd1,
    e_src_q_mem_resp = 3'd2
  } cce_src_q_e;

  typedef enum logic {
    e_src_sel_gpr = 1'b0,
    e_src_sel_imm = 1'b1
  } cce_src_sel_e;

  // Field view of a raw instruction, dst and src_a double as queue selects
  typedef struct packed {
    cce_op_e      op;
    cce_minor_e   minor;
    cce_gpr_idx_t dst;
    cce_gpr_idx_t src_a;
    cce_gpr_idx_t src_b;
    logic         src_b_imm;
    cce_imm_t     imm;
  } cce_inst_s;

  // Control word handed to the execute stage
  typedef struct packed {
    cce_op_e       op;
    cce_minor_e    minor;
    logic          alu_v;
    logic          branch_v;
    cce_gpr_mask_t gpr_w_mask;
    cce_gpr_idx_t  src_a;
    cce_gpr_idx_t  src_b;
    cce_src_sel_e  src_b_sel;
    cce_imm_t      imm;
    logic          lce_cmd_v;
    logic          mem_cmd_v;
    logic          lce_req_yumi;
    logic          lce_resp_yumi;
    logic          mem_resp_yumi;
  } cce_decoded_s;

endpackage

//--- design/cce_fetch_stall.sv
`timescale 1ns/1ps
`include "cce_params.svh"

module cce_fetch_stall (
  input  cce_pkg::cce_inst_t inst_i,
  input  logic               inst_v_i,

  // Input queue valids
  input  logic               lce_req_v_i,
  input  logic               lce_resp_v_i,
  input  logic               mem_resp_v_i,
  input  logic               pending_v_i,

  // Output queue readies
  input  logic               lce_cmd_ready_i,
  input  logic               mem_cmd_ready_i,

  // Message unit busy levels
  input  logic               lce_cmd_busy_i,
  input  logic               pending_w_busy_i,

  output logic               stall_o
);

  import cce_pkg::*;

  cce_inst_s   inst;
  cce_q_mask_t q_v_vec;
  cce_q_mask_t wfq_mask;
  logic        stall_op;
  logic        wfq_op;
  logic        pushq_op;
  logic        pop_op;
  logic        wfq_blocked;
  logic        push_blocked;
  logic        pop_empty;

  assign inst = inst_i;

  // Same bit order as the wfq mask
  assign q_v_vec  = {lce_req_v_i, lce_resp_v_i, mem_resp_v_i, pending_v_i};
  assign wfq_mask = inst.imm[`CCE_NUM_SRC_Q-1:0];

  assign stall_op = (inst.op == e_op_misc) && (inst.minor == e_stall_op);
  assign wfq_op   = (inst.op == e_op_queue) && (inst.minor == e_wfq_op);
  assign pushq_op = (inst.op == e_op_queue) && (inst.minor == e_pushq_op);
  assign pop_op   = (inst.op == e_op_queue)
                    && ((inst.minor == e_popq_op) || (inst.minor == e_poph_op));

  // Wait until any watched source has something
  assign wfq_blocked = ~|(wfq_mask & q_v_vec);

  // Push target full, or the message unit is still using it
  always_comb begin
    case (cce_dst_q_e'(inst.dst))
      e_dst_q_lce_cmd: push_blocked = ~lce_cmd_ready_i | lce_cmd_busy_i;
      e_dst_q_mem_cmd: push_blocked = ~mem_cmd_ready_i | pending_w_busy_i;
      default:         push_blocked = 1'b0;
    endcase
  end

  // popq and poph both need data at the head
  always_comb begin
    case (cce_src_q_e'(inst.src_a))
      e_src_q_lce_req:  pop_empty = ~lce_req_v_i;
      e_src_q_lce_resp: pop_empty = ~lce_resp_v_i;
      e_src_q_mem_resp: pop_empty = ~mem_resp_v_i;
      default:          pop_empty = 1'b0;
    endcase
  end

  assign stall_o = inst_v_i & (stall_op
                               | (wfq_op & wfq_blocked)
                               | (pushq_op & push_blocked)
                               | (pop_op & pop_empty));

endmodule

//--- design/cce_inst_decode.sv
`timescale 1ns/1ps
`include "cce_params.svh"

module cce_inst_decode (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  // Instruction from fetch
  input  cce_pkg::cce_inst_t    inst_i,
  input  logic                  inst_v_i,

  // Stall level from the stall unit, masks all enables
  input  logic                  stall_i,

  // Input queue valids, a yumi is only raised against one of these
  input  logic                  lce_req_v_i,
  input  logic                  lce_resp_v_i,
  input  logic                  mem_resp_v_i,

  output cce_pkg::cce_decoded_s decoded_o,
  output logic                  decoded_v_o,
  output cce_pkg::cce_pc_t      pc_branch_target_o
);

  import cce_pkg::*;

  cce_inst_s    inst;
  cce_dst_q_e   dst_q;
  cce_src_q_e   src_q;
  cce_decoded_s decoded_d;
  cce_decoded_s decoded_q;
  logic         decoded_v_q;
  logic         gpr_w_v;

  assign inst  = inst_i;
  assign dst_q = cce_dst_q_e'(inst.dst);
  assign src_q = cce_src_q_e'(inst.src_a);

  // Target goes back to fetch in the same cycle
  assign pc_branch_target_o = (inst_v_i && (inst.op == e_op_branch)) ?
                              inst.imm[`CCE_PC_W-1:0] : '0;

  always_comb begin
    decoded_d = '0;
    gpr_w_v   = 1'b0;

    if (inst_v_i) begin
      decoded_d.op        = inst.op;
      decoded_d.minor     = inst.minor;
      decoded_d.src_a     = inst.src_a;
      decoded_d.src_b     = inst.src_b;
      decoded_d.imm       = inst.imm;
      decoded_d.src_b_sel = inst.src_b_imm ? e_src_sel_imm : e_src_sel_gpr;

      case (inst.op)
        e_op_alu: begin
          // Every ALU op writes its result to dst
          if (inst.minor inside {e_add_op, e_sub_op, e_and_op, e_or_op}) begin
            decoded_d.alu_v = 1'b1;
            gpr_w_v         = 1'b1;
          end
        end
        e_op_branch: begin
          decoded_d.branch_v = inst.minor inside {e_beq_op, e_bne_op, e_bi_op};
        end
        e_op_move: begin
          // mov copies src_a, movi always takes the immediate
          if (inst.minor == e_movi_op) begin
            decoded_d.src_b_sel = e_src_sel_imm;
            gpr_w_v             = 1'b1;
          end else if (inst.minor == e_mov_op) begin
            gpr_w_v = 1'b1;
          end
        end
        e_op_queue: begin
          case (inst.minor)
            e_pushq_op: begin
              decoded_d.lce_cmd_v = (dst_q == e_dst_q_lce_cmd);
              decoded_d.mem_cmd_v = (dst_q == e_dst_q_mem_cmd);
            end
            e_popq_op: begin
              decoded_d.lce_req_yumi  = lce_req_v_i  && (src_q == e_src_q_lce_req);
              decoded_d.lce_resp_yumi = lce_resp_v_i && (src_q == e_src_q_lce_resp);
              decoded_d.mem_resp_yumi = mem_resp_v_i && (src_q == e_src_q_mem_resp);
              // LCE response type lands in the dst GPR
              gpr_w_v = (src_q == e_src_q_lce_resp);
            end
            // poph only looks at the head, wfq is handled by the stall unit
            default: begin
            end
          endcase
        end
        default: begin
        end
      endcase

      decoded_d.gpr_w_mask = (gpr_w_v && !stall_i) ?
                             (cce_gpr_mask_t'(1) << inst.dst) : '0;

      // Held instruction is replayed by fetch, so nothing may take effect now
      if (stall_i) begin
        decoded_d.lce_cmd_v     = 1'b0;
        decoded_d.mem_cmd_v     = 1'b0;
        decoded_d.lce_req_yumi  = 1'b0;
        decoded_d.lce_resp_yumi = 1'b0;
        decoded_d.mem_resp_yumi = 1'b0;
      end
    end
  end

  // Execute register
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      decoded_q   <= '0;
      decoded_v_q <= 1'b0;
    end else begin
      decoded_q   <= decoded_d;
      decoded_v_q <= inst_v_i;
    end
  end

  assign decoded_o   = decoded_q;
  assign decoded_v_o = decoded_v_q;

  a_gpr_mask_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(decoded_o.gpr_w_mask)
  );

  a_single_yumi: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0({decoded_o.lce_req_yumi, decoded_o.lce_resp_yumi, decoded_o.mem_resp_yumi})
  );

  // Dequeue only against data that was valid on the capturing edge
  a_yumi_has_data: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (({decoded_o.lce_req_yumi, decoded_o.lce_resp_yumi, decoded_o.mem_resp_yumi}
      & ~$past({lce_req_v_i, lce_resp_v_i, mem_resp_v_i})) == 3'b000)
  );

endmodule

//--- design/cce_decode_top.sv
`timescale 1ns/1ps

module cce_decode_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,

  input  cce_pkg::cce_inst_t    inst_i,
  input  logic                  inst_v_i,

  input  logic                  lce_req_v_i,
  input  logic                  lce_resp_v_i,
  input  logic                  mem_resp_v_i,
  input  logic                  pending_v_i,

  input  logic                  lce_cmd_ready_i,
  input  logic                  mem_cmd_ready_i,

  input  logic                  lce_cmd_busy_i,
  input  logic                  pending_w_busy_i,

  output cce_pkg::cce_decoded_s decoded_o,
  output logic                  decoded_v_o,
  output logic                  pc_stall_o,
  output cce_pkg::cce_pc_t      pc_branch_target_o
);

  logic stall;

  cce_fetch_stall stall_i (
    .inst_i           (inst_i),
    .inst_v_i         (inst_v_i),
    .lce_req_v_i      (lce_req_v_i),
    .lce_resp_v_i     (lce_resp_v_i),
    .mem_resp_v_i     (mem_resp_v_i),
    .pending_v_i      (pending_v_i),
    .lce_cmd_ready_i  (lce_cmd_ready_i),
    .mem_cmd_ready_i  (mem_cmd_ready_i),
    .lce_cmd_busy_i   (lce_cmd_busy_i),
    .pending_w_busy_i (pending_w_busy_i),
    .stall_o          (stall)
  );

  cce_inst_decode decode_i (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .inst_i             (inst_i),
    .inst_v_i           (inst_v_i),
    .stall_i            (stall),
    .lce_req_v_i        (lce_req_v_i),
    .lce_resp_v_i       (lce_resp_v_i),
    .mem_resp_v_i       (mem_resp_v_i),
    .decoded_o          (decoded_o),
    .decoded_v_o        (decoded_v_o),
    .pc_branch_target_o (pc_branch_target_o)
  );

  assign pc_stall_o = stall;

  // Fetch only ever holds on a real instruction
  a_no_idle_stall: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !inst_v_i |-> !pc_stall_o
  );

  // A held instruction leaves no side effect in the execute register
  a_stall_masks_enables: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    pc_stall_o |=> ((decoded_o.gpr_w_mask == '0) && !decoded_o.lce_cmd_v
                    && !decoded_o.mem_cmd_v && !decoded_o.lce_req_yumi
                    && !decoded_o.lce_resp_yumi && !decoded_o.mem_resp_yumi)
  );

endmodule

//--- sim/tb_cce_decode.sv
`timescale 1ns/1ps
`include "cce_params.svh"

module tb_cce_decode;

  import cce_pkg::*;

  localparam int RESET_CYCLES    = 4;
  localparam int DIRECTED_CYCLES = 120;
  localparam int RANDOM_CYCLES   = 400;
  // Margin on top of the expected run length
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES + 76;

  logic         clk;
  logic         arst_n;
  cce_inst_t    inst;
  logic         inst_v;
  // Queue valids from lce_req down to pending
  logic [3:0]   q_v;
  logic         lce_cmd_ready;
  logic         mem_cmd_ready;
  logic         lce_cmd_busy;
  logic         pending_w_busy;

  cce_decoded_s decoded;
  logic         decoded_v;
  logic         pc_stall;
  cce_pc_t      target;

  cce_decoded_s exp_word_q;
  logic         exp_v_q;
  logic         exp_stall;
  cce_pc_t      exp_target;

  int           errors = 0;
  int           cycles = 0;
  logic [31:0]  rng_state = 32'h9d33_9cd4;

  cce_decode_top dut_i (
    .clk_i              (clk),
    .arst_n_i           (arst_n),
    .inst_i             (inst),
    .inst_v_i           (inst_v),
    .lce_req_v_i        (q_v[3]),
    .lce_resp_v_i       (q_v[2]),
    .mem_resp_v_i       (q_v[1]),
    .pending_v_i        (q_v[0]),
    .lce_cmd_ready_i    (lce_cmd_ready),
    .mem_cmd_ready_i    (mem_cmd_ready),
    .lce_cmd_busy_i     (lce_cmd_busy),
    .pending_w_busy_i   (pending_w_busy),
    .decoded_o          (decoded),
    .decoded_v_o        (decoded_v),
    .pc_stall_o         (pc_stall),
    .pc_branch_target_o (target)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic cce_inst_t make_inst(logic [2:0] op, logic [2:0] minor, logic [2:0] dst,
                                          logic [2:0] src_a, logic [2:0] src_b,
                                          logic imm_f, logic [15:0] imm);
    return {op, minor, dst, src_a, src_b, imm_f, imm};
  endfunction

  // Legal instructions with queue selects inside their ranges
  function automatic cce_inst_t random_inst(logic [31:0] r, logic [31:0] s);
    logic [2:0]  op;
    logic [2:0]  minor;
    logic [2:0]  dst;
    logic [2:0]  src;
    logic [15:0] imm;
    op  = r[2:0] % 3'd5;
    dst = r[8:6];
    src = r[11:9];
    imm = s[31:16];
    case (op)
      e_op_alu, e_op_queue: minor = {1'b0, r[4:3]};
      e_op_branch:          minor = (r[4:3] == 2'd3) ? 3'd2 : {1'b0, r[4:3]};
      e_op_move:            minor = {2'b00, r[3]};
      default:              minor = 3'd0;
    endcase
    if (op == e_op_queue) begin
      src = (r[10:9] == 2'd3) ? 3'd1 : {1'b0, r[10:9]};
      if (minor == e_pushq_op) dst = {2'b00, r[6]};
      // An empty wfq mask could never be satisfied
      if (minor == e_wfq_op && imm[3:0] == 4'h0) imm[3:0] = 4'h8;
    end
    return {op, minor, dst, src, s[2:0], s[3], imm};
  endfunction

  // Stall rules for a valid instruction
  function automatic logic predict_stall(cce_inst_t i, logic v, logic [3:0] qv,
                                         logic [1:0] rdy, logic [1:0] busy);
    logic [2:0] op;
    logic [2:0] minor;
    logic       stall;
    op    = i[31:29];
    minor = i[28:26];
    stall = 1'b0;
    if (v && op == e_op_misc && minor == e_stall_op) stall = 1'b1;
    if (v && op == e_op_queue) begin
      case (minor)
        e_pushq_op: stall = (i[25:23] == 3'd0) ? (!rdy[1] || busy[1]) :
                            (i[25:23] == 3'd1) ? (!rdy[0] || busy[0]) : 1'b0;
        e_popq_op, e_poph_op: begin
          case (i[22:20])
            3'd0:    stall = !qv[3];
            3'd1:    stall = !qv[2];
            3'd2:    stall = !qv[1];
            default: stall = 1'b0;
          endcase
        end
        e_wfq_op: stall = ((i[3:0] & qv) == 4'b0000);
        default:  stall = 1'b0;
      endcase
    end
    return stall;
  endfunction

  function automatic cce_pc_t branch_target(cce_inst_t i, logic v);
    return (v && i[31:29] == e_op_branch) ? i[`CCE_PC_W-1:0] : '0;
  endfunction

  // Word the execute register should hold one edge after this instruction
  function automatic cce_decoded_s expected_word(cce_inst_t i, logic v, logic stall);
    cce_decoded_s w;
    logic [2:0]   op;
    logic [2:0]   minor;
    logic         writes_gpr;
    w     = '0;
    op    = i[31:29];
    minor = i[28:26];
    if (v) begin
      w.op        = cce_op_e'(op);
      w.minor     = cce_minor_e'(minor);
      w.src_a     = i[22:20];
      w.src_b     = i[19:17];
      w.imm       = i[15:0];
      w.src_b_sel = cce_src_sel_e'(i[16] || (op == e_op_move && minor == e_movi_op));
      w.alu_v     = (op == e_op_alu);
      w.branch_v  = (op == e_op_branch);
      writes_gpr  = (op == e_op_alu) || (op == e_op_move)
                    || (op == e_op_queue && minor == e_popq_op && i[22:20] == 3'd1);
      if (!stall) begin
        if (writes_gpr) w.gpr_w_mask[i[25:23]] = 1'b1;
        if (op == e_op_queue && minor == e_pushq_op) begin
          w.lce_cmd_v = (i[25:23] == 3'd0);
          w.mem_cmd_v = (i[25:23] == 3'd1);
        end
        if (op == e_op_queue && minor == e_popq_op) begin
          w.lce_req_yumi  = (i[22:20] == 3'd0);
          w.lce_resp_yumi = (i[22:20] == 3'd1);
          w.mem_resp_yumi = (i[22:20] == 3'd2);
        end
      end
    end
    return w;
  endfunction

  function automatic logic [14:0] enable_bits(cce_decoded_s w);
    return {w.alu_v, w.branch_v, w.gpr_w_mask, w.lce_cmd_v, w.mem_cmd_v,
            w.lce_req_yumi, w.lce_resp_yumi, w.mem_resp_yumi};
  endfunction

  function automatic logic [2:0] yumi_bits(cce_decoded_s w);
    return {w.lce_req_yumi, w.lce_resp_yumi, w.mem_resp_yumi};
  endfunction

  task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    errors = errors + 1;
    $display("ERR time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
  endtask

  assign exp_stall  = predict_stall(inst, inst_v, q_v, {lce_cmd_ready, mem_cmd_ready},
                                    {lce_cmd_busy, pending_w_busy});
  assign exp_target = branch_target(inst, inst_v);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      exp_word_q <= '0;
      exp_v_q    <= 1'b0;
    end else begin
      exp_word_q <= expected_word(inst, inst_v, exp_stall);
      exp_v_q    <= inst_v;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> (!decoded_v && enable_bits(decoded) == '0))
    else report_mismatch("decoded_v_o/enables", 32'h0,
                         32'({$sampled(decoded_v), enable_bits($sampled(decoded))}));

  a_stall: assert property (@(posedge clk) pc_stall == exp_stall)
    else report_mismatch("pc_stall_o", 32'($sampled(exp_stall)), 32'($sampled(pc_stall)));

  a_target: assert property (@(posedge clk) target == exp_target)
    else report_mismatch("pc_branch_target_o", 32'($sampled(exp_target)),
                         32'($sampled(target)));

  a_valid: assert property (@(posedge clk) disable iff (!arst_n) decoded_v == exp_v_q)
    else report_mismatch("decoded_v_o", 32'($sampled(exp_v_q)), 32'($sampled(decoded_v)));

  a_gpr_mask: assert property (@(posedge clk) disable iff (!arst_n)
    decoded.gpr_w_mask == exp_word_q.gpr_w_mask)
    else report_mismatch("decoded_o.gpr_w_mask", 32'($sampled(exp_word_q.gpr_w_mask)),
                         32'($sampled(decoded.gpr_w_mask)));

  a_src_fields: assert property (@(posedge clk) disable iff (!arst_n)
    {decoded.src_a, decoded.src_b} == {exp_word_q.src_a, exp_word_q.src_b})
    else report_mismatch("decoded_o.src_a/src_b",
                         32'({$sampled(exp_word_q.src_a), $sampled(exp_word_q.src_b)}),
                         32'({$sampled(decoded.src_a), $sampled(decoded.src_b)}));

  a_imm: assert property (@(posedge clk) disable iff (!arst_n)
    decoded.imm == exp_word_q.imm)
    else report_mismatch("decoded_o.imm", 32'($sampled(exp_word_q.imm)),
                         32'($sampled(decoded.imm)));

  a_src_b_sel: assert property (@(posedge clk) disable iff (!arst_n)
    decoded.src_b_sel == exp_word_q.src_b_sel)
    else report_mismatch("decoded_o.src_b_sel", 32'($sampled(exp_word_q.src_b_sel)),
                         32'($sampled(decoded.src_b_sel)));

  a_class: assert property (@(posedge clk) disable iff (!arst_n)
    {decoded.op, decoded.minor, decoded.alu_v, decoded.branch_v}
      == {exp_word_q.op, exp_word_q.minor, exp_word_q.alu_v, exp_word_q.branch_v})
    else report_mismatch("decoded_o.op/minor/alu_v/branch_v",
                         32'({$sampled(exp_word_q.op), $sampled(exp_word_q.minor),
                              $sampled(exp_word_q.alu_v), $sampled(exp_word_q.branch_v)}),
                         32'({$sampled(decoded.op), $sampled(decoded.minor),
                              $sampled(decoded.alu_v), $sampled(decoded.branch_v)}));

  a_cmd_valid: assert property (@(posedge clk) disable iff (!arst_n)
    {decoded.lce_cmd_v, decoded.mem_cmd_v} == {exp_word_q.lce_cmd_v, exp_word_q.mem_cmd_v})
    else report_mismatch("decoded_o.lce_cmd_v/mem_cmd_v",
                         32'({$sampled(exp_word_q.lce_cmd_v), $sampled(exp_word_q.mem_cmd_v)}),
                         32'({$sampled(decoded.lce_cmd_v), $sampled(decoded.mem_cmd_v)}));

  a_yumi: assert property (@(posedge clk) disable iff (!arst_n)
    yumi_bits(decoded) == yumi_bits(exp_word_q))
    else report_mismatch("decoded_o yumis", 32'(yumi_bits($sampled(exp_word_q))),
                         32'(yumi_bits($sampled(decoded))));

  // Run limit
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
               TIMEOUT_CYCLES, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic drive(cce_inst_t i, logic v, logic [3:0] qv, logic [1:0] rdy,
                       logic [1:0] busy);
    @(negedge clk);
    inst                           = i;
    inst_v                         = v;
    q_v                            = qv;
    {lce_cmd_ready, mem_cmd_ready} = rdy;
    {lce_cmd_busy, pending_w_busy} = busy;
  endtask

  task automatic wait_release();
    @(posedge clk);
    while (pc_stall) @(posedge clk);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] s;
    logic        hold;

    arst_n         = 1'b0;
    inst           = '0;
    inst_v         = 1'b0;
    q_v            = 4'h0;
    lce_cmd_ready  = 1'b0;
    mem_cmd_ready  = 1'b0;
    lce_cmd_busy   = 1'b0;
    pending_w_busy = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // ALU ops with the immediate flag on some
    drive(make_inst(e_op_alu, e_add_op, 3'd5, 3'd1, 3'd2, 1'b0, 16'h1234), 1'b1, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_alu, e_sub_op, 3'd0, 3'd7, 3'd3, 1'b1, 16'h00ff), 1'b1, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_alu, e_and_op, 3'd7, 3'd2, 3'd6, 1'b0, 16'h8001), 1'b1, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_alu, e_or_op, 3'd3, 3'd4, 3'd5, 1'b1, 16'hbeef), 1'b1, 4'hf, 2'b11, 2'b00);
    // movi without the flag still selects the immediate
    drive(make_inst(e_op_move, e_mov_op, 3'd2, 3'd6, 3'd1, 1'b0, 16'h0042), 1'b1, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_move, e_movi_op, 3'd6, 3'd0, 3'd0, 1'b0, 16'hc0de), 1'b1, 4'hf, 2'b11, 2'b00);
    // Branches with the last one invalid
    drive(make_inst(e_op_branch, e_beq_op, 3'd0, 3'd1, 3'd2, 1'b0, 16'h1a5c), 1'b1, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_branch, e_bne_op, 3'd0, 3'd3, 3'd4, 1'b1, 16'h00c3), 1'b1, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_branch, e_bi_op, 3'd0, 3'd0, 3'd0, 1'b1, 16'hff7e), 1'b1, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_branch, e_bi_op, 3'd0, 3'd0, 3'd0, 1'b1, 16'h0099), 1'b0, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_misc, e_stall_op, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0000), 1'b1, 4'hf, 2'b11, 2'b00);
    drive(make_inst(e_op_misc, e_stall_op, 3'd0, 3'd0, 3'd0, 1'b0, 16'h0000), 1'b1, 4'h0, 2'b00, 2'b11);
    // wfq on lce_req and mem_resp
    drive(make_inst(e_op_queue, e_wfq_op, 3'd0, 3'd0, 3'd0, 1'b0, 16'h000a), 1'b1, 4'h5, 2'b11, 2'b00);
    drive(make_inst(e_op_queue, e_wfq_op, 3'd0, 3'd0, 3'd0, 1'b0, 16'h000a), 1'b1, 4'h4, 2'b11, 2'b00);
    drive(make_inst(e_op_queue, e_wfq_op, 3'd0, 3'd0, 3'd0, 1'b0, 16'h000a), 1'b1, 4'h2, 2'b11, 2'b00);
    wait_release();
    // Push to each target through not ready, busy and free
    drive(make_inst(e_op_queue, e_pushq_op, 3'd0, 3'd2, 3'd0, 1'b0, 16'h0001), 1'b1, 4'hf, 2'b01, 2'b00);
    drive(make_inst(e_op_queue, e_pushq_op, 3'd0, 3'd2, 3'd0, 1'b0, 16'h0001), 1'b1, 4'hf, 2'b11, 2'b10);
    drive(make_inst(e_op_queue, e_pushq_op, 3'd0, 3'd2, 3'd0, 1'b0, 16'h0001), 1'b1, 4'hf, 2'b11, 2'b00);
    wait_release();
    drive(make_inst(e_op_queue, e_pushq_op, 3'd1, 3'd5, 3'd0, 1'b0, 16'h0002), 1'b1, 4'hf, 2'b10, 2'b00);
    drive(make_inst(e_op_queue, e_pushq_op, 3'd1, 3'd5, 3'd0, 1'b0, 16'h0002), 1'b1, 4'hf, 2'b11, 2'b01);
    drive(make_inst(e_op_queue, e_pushq_op, 3'd1, 3'd5, 3'd0, 1'b0, 16'h0002), 1'b1, 4'hf, 2'b11, 2'b00);
    wait_release();
    // popq from each source with an empty queue first
    drive(make_inst(e_op_queue, e_popq_op, 3'd4, 3'd0, 3'd0, 1'b0, 16'h0000), 1'b1, 4'h7, 2'b11, 2'b00);
    drive(make_inst(e_op_queue, e_popq_op, 3'd4, 3'd0, 3'd0, 1'b0, 16'h0000), 1'b1, 4'h8, 2'b11, 2'b00);
    wait_release();
    drive(make_inst(e_op_queue, e_popq_op, 3'd6, 3'd1, 3'd0, 1'b0, 16'h0000), 1'b1, 4'hb, 2'b11, 2'b00);
    drive(make_inst(e_op_queue, e_popq_op, 3'd6, 3'd1, 3'd0, 1'b0, 16'h0000), 1'b1, 4'h4, 2'b11, 2'b00);
    wait_release();
    drive(make_inst(e_op_queue, e_popq_op, 3'd1, 3'd2, 3'd0, 1'b0, 16'h0000), 1'b1, 4'hd, 2'b11, 2'b00);
    drive(make_inst(e_op_queue, e_popq_op, 3'd1, 3'd2, 3'd0, 1'b0, 16'h0000), 1'b1, 4'h2, 2'b11, 2'b00);
    wait_release();
    // Peek leaves the queue alone
    drive(make_inst(e_op_queue, e_poph_op, 3'd3, 3'd1, 3'd0, 1'b0, 16'h0000), 1'b1, 4'h0, 2'b11, 2'b00);
    drive(make_inst(e_op_queue, e_poph_op, 3'd3, 3'd1, 3'd0, 1'b0, 16'h0000), 1'b1, 4'h4, 2'b11, 2'b00);
    wait_release();
    drive('0, 1'b0, 4'h0, 2'b11, 2'b00);

    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      @(negedge clk);
      // Fetch replays a held instruction
      // A stall op is dropped so the stream moves on
      hold = pc_stall && (inst[31:29] != e_op_misc);
      r    = next_rand();
      s    = next_rand();
      if (!hold) begin
        inst   = random_inst(r, s);
        inst_v = (r[31:29] != 3'd0);
      end
      q_v            = r[23:20];
      lce_cmd_ready  = (r[25:24] != 2'd0);
      mem_cmd_ready  = (r[27:26] != 2'd0);
      lce_cmd_busy   = (s[9:8] == 2'd3);
      pending_w_busy = (s[11:10] == 2'd3);
    end

    @(negedge clk);
    inst_v = 1'b0;
    // Last word lands in the execute register one edge later
    repeat (2) @(posedge clk);
    $display("Run complete: %0d errors over %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+design
design/cce_pkg.sv
design/cce_fetch_stall.sv
design/cce_inst_decode.sv
design/cce_decode_top.sv
sim/tb_cce_decode.sv

//--- Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_cce_decode
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulator exits cleanly and prints the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -eq 0 ] && echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	  echo "make: run passed"; \
	else \
	  echo "make: run failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
